// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_hiscore
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hdl/hiscore_cfg_decode.sv ====
`timescale 1ns/10ps
`include "hiscore_params.svh"

module hiscore_cfg_decode
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  hiscore_pkg::ioctl_addr_t ioctl_addr,
	input  hiscore_pkg::byte_t       ioctl_index,
	input  hiscore_pkg::byte_t       data_from_hps,
	input  hiscore_pkg::entry_idx_t  entry,
	output logic                     configured,
	output hiscore_pkg::wait_t       start_wait,
	output hiscore_pkg::wait_t       check_wait,
	output hiscore_pkg::byte_t       pause_pad,
	output hiscore_pkg::entry_idx_t  last_entry,
	output hiscore_pkg::ram_addr_t   entry_base,
	output hiscore_pkg::byte_t       entry_len,
	output hiscore_pkg::byte_t       start_val,
	output hiscore_pkg::byte_t       end_val
);
	import hiscore_pkg::*;

	byte_t       hist1;       // Previous config byte
	byte_t       hist2;
	byte_t       hist3;
	logic        last_dl;     // ioctl_download one cycle ago
	byte_t       last_index;
	logic        downloading;
	logic        in_header;
	logic        hdr_wr;
	logic        ent_wr;
	ioctl_addr_t ent_off;     // Offset past the header
	entry_idx_t  wr_idx;      // Table row being loaded
	logic [2:0]  ent_byte;    // Byte within the entry
	logic [15:0] base_word;   // Low half of the big-endian address

	assign downloading = ioctl_download && (ioctl_index == byte_t'(`HS_CONFIG_INDEX));
	assign in_header   = (ioctl_addr < ioctl_addr_t'(`HS_HEADER_LEN));
	assign hdr_wr      = downloading && in_header && ioctl_wr;
	assign ent_wr      = downloading && !in_header && ioctl_wr;
	assign ent_off     = ioctl_addr - ioctl_addr_t'(`HS_HEADER_LEN);
	assign wr_idx      = entry_idx_t'(ent_off / `HS_ENTRY_LEN);
	assign ent_byte    = 3'(ent_off % `HS_ENTRY_LEN);
	assign base_word   = {hist1, data_from_hps};

	// Byte history for multi-byte fields
	always_ff @(posedge clk)
	begin
		if (downloading && ioctl_wr)
		begin
			hist3 <= hist2;
			hist2 <= hist1;
			hist1 <= data_from_hps;
		end
	end

	// ------------------------------------------------------------
	// Header fields, latched on their last byte
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			start_wait <= '0;
			check_wait <= wait_t'(16'h00FF);
			pause_pad  <= 8'd4;
		end
		else if (hdr_wr)
		begin
			case (ioctl_addr[3:0])
				4'd3:    start_wait <= {hist3, hist2, hist1, data_from_hps};
				4'd5:    check_wait <= wait_t'({hist1, data_from_hps});
				4'd14:   pause_pad  <= data_from_hps;
				default: ;  // Repeat and hold fields unused
			endcase
		end
	end

	// Entry count and end of transfer
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			last_dl    <= 1'b0;
			last_index <= '0;
			last_entry <= '0;
			configured <= 1'b0;
		end
		else
		begin
			last_dl    <= ioctl_download;
			last_index <= ioctl_index;
			if (ent_wr && (wr_idx > last_entry))
				last_entry <= wr_idx;
			if (last_dl && !ioctl_download && (last_index == byte_t'(`HS_CONFIG_INDEX)))
				configured <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Entry tables, written on A, read by entry on B
	// ------------------------------------------------------------
	hiscore_dpram #(.data_w(`HS_ADDR_W), .addr_w(`HS_CFG_W)) i_base_tbl
	(
		.clk(clk), .arst_n(arst_n),
		.addr_a(wr_idx), .d_a(base_word[`HS_ADDR_W-1:0]), .we_a(ent_wr && (ent_byte == 3'd3)),
		.q_a(),
		.addr_b(entry), .d_b('0), .we_b(1'b0), .q_b(entry_base)
	);

	hiscore_dpram #(.data_w(8), .addr_w(`HS_CFG_W)) i_len_tbl
	(
		.clk(clk), .arst_n(arst_n),
		.addr_a(wr_idx), .d_a(data_from_hps), .we_a(ent_wr && (ent_byte == 3'd4)), .q_a(),
		.addr_b(entry), .d_b('0), .we_b(1'b0), .q_b(entry_len)
	);

	hiscore_dpram #(.data_w(8), .addr_w(`HS_CFG_W)) i_start_tbl
	(
		.clk(clk), .arst_n(arst_n),
		.addr_a(wr_idx), .d_a(data_from_hps), .we_a(ent_wr && (ent_byte == 3'd5)), .q_a(),
		.addr_b(entry), .d_b('0), .we_b(1'b0), .q_b(start_val)
	);

	hiscore_dpram #(.data_w(8), .addr_w(`HS_CFG_W)) i_end_tbl
	(
		.clk(clk), .arst_n(arst_n),
		.addr_a(wr_idx), .d_a(data_from_hps), .we_a(ent_wr && (ent_byte == 3'd6)), .q_a(),
		.addr_b(entry), .d_b('0), .we_b(1'b0), .q_b(end_val)
	);

	// Config stays valid for good once loaded
	a_cfg_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		configured |=> configured);

endmodule

// ==== hdl/hiscore_dpram.sv ====
`timescale 1ns/10ps

module hiscore_dpram
#(
	parameter int data_w = 8,
	parameter int addr_w = 8
)
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [addr_w-1:0] addr_a,
	input  logic [data_w-1:0] d_a,
	input  logic              we_a,
	output logic [data_w-1:0] q_a,
	input  logic [addr_w-1:0] addr_b,
	input  logic [data_w-1:0] d_b,
	input  logic              we_b,
	output logic [data_w-1:0] q_b
);
	logic [data_w-1:0] mem [2**addr_w];

	always_ff @(posedge clk)
	begin
		if (we_a)
			mem[addr_a] <= d_a;
		if (we_b)
			mem[addr_b] <= d_b;  // B wins on a same-address clash
	end

	// Registered read, write data passes straight through
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			q_a <= '0;
			q_b <= '0;
		end
		else
		begin
			q_a <= we_a ? d_a : mem[addr_a];
			q_b <= we_b ? d_b : mem[addr_b];
		end
	end

endmodule

// ==== hdl/hiscore_dump_store.sv ====
`timescale 1ns/10ps
`include "hiscore_params.svh"

module hiscore_dump_store
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ioctl_download,
	input  logic                    ioctl_upload,
	input  logic                    ioctl_wr,
	input  hiscore_pkg::ioctl_addr_t ioctl_addr,
	input  hiscore_pkg::byte_t      ioctl_index,
	input  hiscore_pkg::byte_t      data_from_hps,
	input  hiscore_pkg::dump_addr_t dump_addr,
	output logic                    dump_loaded,
	output logic                    uploading,
	output hiscore_pkg::byte_t      data_to_ram,
	output hiscore_pkg::byte_t      data_to_hps
);
	import hiscore_pkg::*;

	logic       downloading;
	logic       last_dl;
	byte_t      last_index;
	dump_addr_t rd_addr;    // Upload address wins over the sequencer
	byte_t      rd_byte;

	assign downloading = ioctl_download && (ioctl_index == byte_t'(`HS_DUMP_INDEX));
	assign uploading   = ioctl_upload && (ioctl_index == byte_t'(`HS_DUMP_INDEX));
	assign rd_addr     = uploading ? ioctl_addr[`HS_SCORE_W-1:0] : dump_addr;
	assign data_to_ram = rd_byte;  // Same read register serves both sides
	assign data_to_hps = rd_byte;

	hiscore_dpram #(.data_w(8), .addr_w(`HS_SCORE_W)) i_dump_ram
	(
		.clk(clk), .arst_n(arst_n),
		.addr_a(ioctl_addr[`HS_SCORE_W-1:0]), .d_a(data_from_hps),
		.we_a(downloading && ioctl_wr), .q_a(),
		.addr_b(rd_addr), .d_b('0), .we_b(1'b0), .q_b(rd_byte)
	);

	// Dump is usable once its download has ended
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			last_dl     <= 1'b0;
			last_index  <= '0;
			dump_loaded <= 1'b0;
		end
		else
		begin
			last_dl    <= ioctl_download;
			last_index <= ioctl_index;
			if (last_dl && !ioctl_download && (last_index == byte_t'(`HS_DUMP_INDEX)))
				dump_loaded <= 1'b1;
		end
	end

endmodule

// ==== hdl/hiscore_params.svh ====
`ifndef HISCORE_PARAMS_SVH
`define HISCORE_PARAMS_SVH

// ------------------------------------------------------------
// Widths
// ------------------------------------------------------------
`define HS_ADDR_W       10  // Game RAM address bits
`define HS_SCORE_W      8   // Dump RAM address bits, 256 bytes max
`define HS_CFG_W        4   // Entry index bits, 16 entries max

// ------------------------------------------------------------
// Host transfer layout
// ------------------------------------------------------------
`define HS_CONFIG_INDEX 3   // ioctl index of the configuration file
`define HS_DUMP_INDEX   4   // ioctl index of the score dump
`define HS_HEADER_LEN   16  // Config header bytes
`define HS_ENTRY_LEN    8   // Bytes per config entry

`endif

// ==== hdl/hiscore_pkg.sv ====
`include "hiscore_params.svh"

package hiscore_pkg;

	typedef logic [7:0]               byte_t;        // Data byte
	typedef logic [24:0]              ioctl_addr_t;  // Host transfer address
	typedef logic [`HS_ADDR_W-1:0]    ram_addr_t;    // Game RAM address
	typedef logic [`HS_SCORE_W-1:0]   dump_addr_t;   // Dump RAM address
	typedef logic [`HS_CFG_W-1:0]     entry_idx_t;   // Config entry index
	typedef logic [31:0]              wait_t;        // Cycle count

	// Restore sequencer states
	typedef enum logic [3:0] {
		RS_IDLE,          // No run yet
		RS_TIMER,         // Count down, then go to next_state
		RS_WAIT_PAUSE,    // Hold pause request until the core confirms
		RS_WAIT_DATA,     // Game RAM strobe out, wait for data_ready edge
		RS_CHECK_BEGIN,   // Read start byte of entry
		RS_CHECK_START,   // Compare start byte, read end byte
		RS_CHECK_END,     // Compare end byte
		RS_CHECK_CANCEL,  // Drop pause and schedule a retry
		RS_WRITE_BEGIN,   // Wait for entry lookup
		RS_WRITE_READY,   // Issue one byte write
		RS_WRITE_DONE,    // Step to next byte or entry
		RS_STOPPED        // Restore finished
	} restore_state_t;

endpackage

// ==== hdl/hiscore_restore_exec.sv ====
`timescale 1ns/10ps

module hiscore_restore_exec
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    game_reset,
	input  logic                    paused,
	input  logic                    data_ready,
	input  hiscore_pkg::byte_t      data_from_ram,
	input  logic                    configured,
	input  logic                    dump_loaded,
	input  logic                    uploading,
	input  hiscore_pkg::wait_t      start_wait,
	input  hiscore_pkg::wait_t      check_wait,
	input  hiscore_pkg::byte_t      pause_pad,
	input  hiscore_pkg::entry_idx_t last_entry,
	input  hiscore_pkg::ram_addr_t  entry_base,
	input  hiscore_pkg::byte_t      entry_len,
	input  hiscore_pkg::byte_t      start_val,
	input  hiscore_pkg::byte_t      end_val,
	output hiscore_pkg::entry_idx_t entry,
	output hiscore_pkg::dump_addr_t dump_addr,
	output hiscore_pkg::ram_addr_t  ram_address,
	output logic                    ram_read,
	output logic                    ram_write,
	output logic                    ram_intent_read,
	output logic                    ram_intent_write,
	output logic                    pause_cpu
);
	import hiscore_pkg::*;

	restore_state_t state;
	restore_state_t next_state;  // Where TIMER and WAIT_DATA go next
	wait_t          wait_timer;
	byte_t          byte_cnt;    // Byte within the current entry
	byte_t          ram_data;    // Last byte returned by game RAM
	entry_idx_t     entry_q;     // Entry seen by the tables
	logic           reset_q;
	logic           data_ready_q;
	logic           lookup_ok;   // Table outputs match entry
	logic           ready_edge;
	logic           run_start;
	logic           active;
	ram_addr_t      end_addr;

	assign lookup_ok  = (entry_q == entry);
	assign ready_edge = data_ready && !data_ready_q;
	assign run_start  = reset_q && !game_reset && configured && dump_loaded;
	assign active     = !uploading && !game_reset;
	assign end_addr   = entry_base + ram_addr_t'(entry_len) - ram_addr_t'(1);

	always_ff @(posedge clk)
	begin
		if (active && (state == RS_WAIT_DATA) && ready_edge)
			ram_data <= data_from_ram;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state            <= RS_IDLE;
			next_state       <= RS_IDLE;
			wait_timer       <= '0;
			byte_cnt         <= '0;
			entry            <= '0;
			entry_q          <= '0;
			dump_addr        <= '0;
			ram_address      <= '0;
			ram_read         <= 1'b0;
			ram_write        <= 1'b0;
			ram_intent_read  <= 1'b0;
			ram_intent_write <= 1'b0;
			pause_cpu        <= 1'b0;
			reset_q          <= 1'b0;
			data_ready_q     <= 1'b0;
		end
		else
		begin
			reset_q      <= game_reset;
			data_ready_q <= data_ready;
			entry_q      <= entry;
			if (run_start)  // New run on every reset release
			begin
				state            <= RS_TIMER;
				wait_timer       <= start_wait;
				next_state       <= RS_WAIT_PAUSE;
				entry            <= '0;
				ram_read         <= 1'b0;
				ram_write        <= 1'b0;
				ram_intent_read  <= 1'b0;
				ram_intent_write <= 1'b0;
				pause_cpu        <= 1'b0;
			end
			else if (active)
			begin
				case (state)
					RS_TIMER:
						if (!paused || pause_cpu)  // Frozen if paused by someone else
						begin
							if (wait_timer != '0)
								wait_timer <= wait_timer - wait_t'(1);
							else
								state <= next_state;
						end
					RS_WAIT_PAUSE:
					begin
						pause_cpu <= 1'b1;
						if (pause_cpu && paused)
						begin
							state      <= RS_TIMER;  // Settle before touching RAM
							wait_timer <= wait_t'(pause_pad);
							next_state <= RS_CHECK_BEGIN;
						end
					end
					RS_WAIT_DATA:
						if (ready_edge)
						begin
							ram_read  <= 1'b0;
							ram_write <= 1'b0;
							state     <= next_state;
						end
					// ------------------------------------------------------------
					// Start/end check of every entry
					// ------------------------------------------------------------
					RS_CHECK_BEGIN:
						if (lookup_ok)
						begin
							ram_intent_read <= 1'b1;
							ram_address     <= entry_base;
							ram_read        <= 1'b1;
							state           <= RS_WAIT_DATA;
							next_state      <= RS_CHECK_START;
						end
					RS_CHECK_START:
						if (ram_data == start_val)
						begin
							ram_address <= end_addr;
							ram_read    <= 1'b1;
							state       <= RS_WAIT_DATA;
							next_state  <= RS_CHECK_END;
						end
						else
						begin
							ram_intent_read <= 1'b0;
							state           <= RS_TIMER;
							wait_timer      <= wait_t'(pause_pad);
							next_state      <= RS_CHECK_CANCEL;
						end
					RS_CHECK_END:
						if (ram_data != end_val)
						begin
							ram_intent_read <= 1'b0;
							state           <= RS_TIMER;
							wait_timer      <= wait_t'(pause_pad);
							next_state      <= RS_CHECK_CANCEL;
						end
						else if (entry == last_entry)  // All checks passed
						begin
							ram_intent_read <= 1'b0;
							entry           <= '0;
							dump_addr       <= '0;
							state           <= RS_WRITE_BEGIN;
						end
						else
						begin
							entry <= entry + entry_idx_t'(1);
							state <= RS_CHECK_BEGIN;
						end
					RS_CHECK_CANCEL:
					begin
						pause_cpu  <= 1'b0;  // Let the game run, try again later
						entry      <= '0;
						state      <= RS_TIMER;
						wait_timer <= check_wait;
						next_state <= RS_WAIT_PAUSE;
					end
					// ------------------------------------------------------------
					// Byte writes, dump data follows dump_addr by one cycle
					// ------------------------------------------------------------
					RS_WRITE_BEGIN:
						if (lookup_ok)
						begin
							ram_intent_write <= 1'b1;
							byte_cnt         <= '0;
							state            <= RS_WRITE_READY;
						end
					RS_WRITE_READY:
					begin
						ram_address <= entry_base + ram_addr_t'(byte_cnt);
						ram_write   <= 1'b1;
						state       <= RS_WAIT_DATA;
						next_state  <= RS_WRITE_DONE;
					end
					RS_WRITE_DONE:
					begin
						dump_addr <= dump_addr + dump_addr_t'(1);
						if (byte_cnt != entry_len - 8'd1)
						begin
							byte_cnt <= byte_cnt + 8'd1;
							state    <= RS_WRITE_READY;
						end
						else if (entry != last_entry)
						begin
							entry <= entry + entry_idx_t'(1);
							state <= RS_WRITE_BEGIN;
						end
						else
						begin
							ram_intent_write <= 1'b0;
							state            <= RS_TIMER;
							wait_timer       <= wait_t'(pause_pad);
							next_state       <= RS_STOPPED;
						end
					end
					RS_IDLE, RS_STOPPED:
						pause_cpu <= 1'b0;
					default:
						state <= RS_IDLE;
				endcase
			end
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		!(ram_read && ram_write));
	a_write_paused: assert property (@(posedge clk) disable iff (!arst_n)
		ram_intent_write |-> pause_cpu);
	// Game RAM is touched only with the CPU confirmed halted
	a_strobe_paused: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(ram_read) || $rose(ram_write)) |-> (pause_cpu && paused));

endmodule

// ==== hdl/hiscore_top.sv ====
`timescale 1ns/10ps

module hiscore_top
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     game_reset,     // Core reset, run starts on its fall
	input  logic                     paused,         // Core confirms CPU halt
	input  logic                     data_ready,     // Game RAM access done on rising edge
	input  hiscore_pkg::byte_t       data_from_ram,
	input  logic                     ioctl_download,
	input  logic                     ioctl_upload,
	input  logic                     ioctl_wr,
	input  hiscore_pkg::ioctl_addr_t ioctl_addr,
	input  hiscore_pkg::byte_t       ioctl_index,
	input  hiscore_pkg::byte_t       data_from_hps,
	output hiscore_pkg::byte_t       data_to_hps,
	output hiscore_pkg::byte_t       data_to_ram,
	output hiscore_pkg::ram_addr_t   ram_address,
	output logic                     ram_read,
	output logic                     ram_write,
	output logic                     ram_intent_read,
	output logic                     ram_intent_write,
	output logic                     pause_cpu,
	output logic                     configured
);
	import hiscore_pkg::*;

	wait_t      start_wait;
	wait_t      check_wait;
	byte_t      pause_pad;
	entry_idx_t last_entry;
	entry_idx_t entry;
	ram_addr_t  entry_base;
	byte_t      entry_len;
	byte_t      start_val;
	byte_t      end_val;
	dump_addr_t dump_addr;
	logic       dump_loaded;
	logic       uploading;

	// ------------------------------------------------------------
	// Config parser, restore FSM, dump store
	// ------------------------------------------------------------
	hiscore_cfg_decode i_cfg_decode
	(
		.clk(clk), .arst_n(arst_n),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_index(ioctl_index), .data_from_hps(data_from_hps),
		.entry(entry), .configured(configured),
		.start_wait(start_wait), .check_wait(check_wait), .pause_pad(pause_pad),
		.last_entry(last_entry), .entry_base(entry_base), .entry_len(entry_len),
		.start_val(start_val), .end_val(end_val)
	);

	hiscore_restore_exec i_restore_exec
	(
		.clk(clk), .arst_n(arst_n),
		.game_reset(game_reset), .paused(paused),
		.data_ready(data_ready), .data_from_ram(data_from_ram),
		.configured(configured), .dump_loaded(dump_loaded), .uploading(uploading),
		.start_wait(start_wait), .check_wait(check_wait), .pause_pad(pause_pad),
		.last_entry(last_entry), .entry_base(entry_base), .entry_len(entry_len),
		.start_val(start_val), .end_val(end_val),
		.entry(entry), .dump_addr(dump_addr), .ram_address(ram_address),
		.ram_read(ram_read), .ram_write(ram_write),
		.ram_intent_read(ram_intent_read), .ram_intent_write(ram_intent_write),
		.pause_cpu(pause_cpu)
	);

	hiscore_dump_store i_dump_store
	(
		.clk(clk), .arst_n(arst_n),
		.ioctl_download(ioctl_download), .ioctl_upload(ioctl_upload), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_index(ioctl_index), .data_from_hps(data_from_hps),
		.dump_addr(dump_addr), .dump_loaded(dump_loaded), .uploading(uploading),
		.data_to_ram(data_to_ram), .data_to_hps(data_to_hps)
	);

endmodule

// ==== tests/hiscore_checker.sv ====
`timescale 1ns/10ps

module hiscore_checker
#(
	parameter int n_dump   = 5,
	parameter int n_writes = 5
)
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  int                       phase,      // Test number driven by the testbench
	input  logic                     done,
	input  logic                     configured,
	input  logic                     ioctl_download,
	input  logic                     ioctl_upload,
	input  hiscore_pkg::ioctl_addr_t ioctl_addr,
	input  hiscore_pkg::byte_t       data_to_hps,
	input  hiscore_pkg::byte_t       data_to_ram,
	input  hiscore_pkg::ram_addr_t   ram_address,
	input  logic                     ram_read,
	input  logic                     ram_write,
	input  logic                     ram_intent_read,
	input  logic                     ram_intent_write,
	input  logic                     pause_cpu,
	input  hiscore_pkg::byte_t       exp_dump [n_dump],
	input  logic [17:0]              exp_writes [n_writes],  // {address, data}
	output int                       error_count
);
	import hiscore_pkg::*;

	int   test_errors;
	int   failed_tests;
	int   cur_phase;
	int   up_count;     // Upload bytes compared
	int   wr_count;     // Restore writes seen
	int   up_addr_q;
	logic dl_q;
	logic dl_ended;     // Config download has ended
	logic up_q;
	logic wr_q;
	logic pause_q;
	logic rd_seen;      // Game RAM read issued during the bad check
	logic saw_cancel;   // pause_cpu dropped after the bad check
	logic closed;

	initial
	begin
		error_count  = 0;
		test_errors  = 0;
		failed_tests = 0;
		cur_phase    = 0;
		up_count     = 0;
		wr_count     = 0;
		up_addr_q    = 0;
		dl_q         = 1'b0;
		dl_ended     = 1'b0;
		up_q         = 1'b0;
		wr_q         = 1'b0;
		pause_q      = 1'b0;
		rd_seen      = 1'b0;
		saw_cancel   = 1'b0;
		closed       = 1'b0;
	end

	function automatic string test_name(input int n);
		case (n)
			1:       return "configured flag";
			2:       return "upload readback";
			3:       return "start byte mismatch";
			4:       return "restore writes";
			5:       return "idle after restore";
			default: return "unknown";
		endcase
	endfunction

	task automatic mismatch(input string what, input int got, input int want);
		$display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, want);
		test_errors++;
	endtask

	task automatic problem(input string what);
		$display("Error at %0t: %s", $time, what);
		test_errors++;
	endtask

	// End-of-test counts, then one result line
	task automatic close_test(input int n);
		if ((n == 2) && (up_count != n_dump))
			problem($sformatf("upload returned %0d bytes instead of %0d", up_count, n_dump));
		if ((n == 3) && !saw_cancel)
			problem("pause_cpu did not fall after a failed start byte read");
		if ((n == 4) && (wr_count != n_writes))
			problem($sformatf("saw %0d restore writes instead of %0d", wr_count, n_writes));
		$display("Test %0d %s: %s", n, test_name(n), (test_errors == 0) ? "ok" : "FAILED");
		error_count += test_errors;
		if (test_errors != 0)
			failed_tests++;
		test_errors = 0;
	endtask

	// ------------------------------------------------------------
	// Per-edge sampling, checks run for the current test
	// ------------------------------------------------------------
	always @(posedge clk)
	begin
		if (arst_n && !closed)
		begin
			if (ram_read && !ram_intent_read)  // Strobes only inside their intent window
				problem("ram_read high without ram_intent_read");
			if (ram_write && !ram_intent_write)
				problem("ram_write high without ram_intent_write");
			case (cur_phase)
				1:
				begin
					if (configured !== dl_ended)  // Low until one cycle past the download
						mismatch("configured", int'(configured), int'(dl_ended));
					if (dl_q && !ioctl_download)
						dl_ended = 1'b1;
				end
				2:
					if (up_q)  // Data lags the address by one cycle
					begin
						if (data_to_hps !== exp_dump[up_addr_q])
							mismatch($sformatf("data_to_hps at address %0d", up_addr_q),
								int'(data_to_hps), int'(exp_dump[up_addr_q]));
						up_count++;
					end
				3:
				begin
					if (ram_write || ram_intent_write)
						problem("write strobe or write intent raised although the start byte check failed");
					if (ram_read)
						rd_seen = 1'b1;
					if (pause_q && !pause_cpu && rd_seen)
						saw_cancel = 1'b1;
				end
				4:
					if (ram_write && !wr_q)
					begin
						if (wr_count >= n_writes)
							problem("more restore writes than in the write list");
						else if ({ram_address, data_to_ram} !== exp_writes[wr_count])
							mismatch($sformatf("write %0d {address, data}", wr_count),
								int'({ram_address, data_to_ram}), int'(exp_writes[wr_count]));
						wr_count++;
					end
				5:
					if (pause_cpu || ram_read || ram_write || ram_intent_read || ram_intent_write)
						problem("pause_cpu, a RAM strobe or a RAM intent is high after the restore");
				default: ;
			endcase
			if (phase != cur_phase)
			begin
				if (cur_phase != 0)
					close_test(cur_phase);
				cur_phase = phase;
			end
			dl_q      = ioctl_download;
			up_q      = ioctl_upload;
			up_addr_q = int'(ioctl_addr);
			wr_q      = ram_write;
			pause_q   = pause_cpu;
			if (done)
			begin
				$display("Tests run: %0d, failed: %0d, errors: %0d", cur_phase - 1, failed_tests,
					error_count);
				closed = 1'b1;
			end
		end
	end

endmodule

// ==== tests/hiscore_patterns.txt ====
// One hex word per slot and @ jumps to a slot
// Slots 00-1F config, 20-24 dump, 28-37 game RAM 010-01F, 38-41 write list as address then data
@00
00 00 00 10 00 20 00 00  // Start wait 0x10 and check wait 0x20
00 00 00 00 00 00 02 00  // Pause pad 2 at offset 14
00 00 00 10 03 A1 A3 00  // Entry 0 base 010 len 3
00 00 00 18 02 B1 B2 00  // Entry 1 base 018 len 2
@20
11 22 33 44 55           // Dump bytes
@28
A1 5C A3 67 0E 91 2D 48  // Game RAM 010-017
B1 B2 7A 03 C6 19 E4 8F  // Game RAM 018-01F
@38
010 11
011 22
012 33
018 44                   // Second entry starts at dump byte 3
019 55

// ==== tests/tb_hiscore.sv ====
`timescale 1ns/10ps
`include "hiscore_params.svh"

module tb_hiscore;
	import hiscore_pkg::*;

	localparam int cfg_n     = `HS_HEADER_LEN + 2 * `HS_ENTRY_LEN;  // Two entries
	localparam int dump_off  = 32;
	localparam int dump_n    = 5;
	localparam int gram_off  = 40;
	localparam int gram_n    = 16;
	localparam int gram_base = 16;   // Image lands at game RAM 010
	localparam int wr_off    = 56;
	localparam int wr_n      = 5;

	logic        clk;
	logic        arst_n;
	logic        game_reset;
	logic        paused;
	logic        data_ready;
	byte_t       data_from_ram;
	logic        ioctl_download;
	logic        ioctl_upload;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	byte_t       ioctl_index;
	byte_t       data_from_hps;
	byte_t       data_to_hps;
	byte_t       data_to_ram;
	ram_addr_t   ram_address;
	logic        ram_read;
	logic        ram_write;
	logic        ram_intent_read;
	logic        ram_intent_write;
	logic        pause_cpu;
	logic        configured;

	logic [15:0] pat [0:wr_off + 2 * wr_n - 1];  // Whole pattern file
	byte_t       gram [0:1023];                  // Game RAM model
	byte_t       exp_dump [dump_n];
	logic [17:0] exp_writes [wr_n];
	int          seed = 29;
	int          phase;
	logic        done;
	logic        pause_d;
	int          error_count;
	int          limit_cycles;
	logic        armed = 1'b0;

	always #2 clk = ~clk;  // 4 ns period

	hiscore_top i_hiscore_top
	(
		.clk(clk), .arst_n(arst_n), .game_reset(game_reset), .paused(paused),
		.data_ready(data_ready), .data_from_ram(data_from_ram),
		.ioctl_download(ioctl_download), .ioctl_upload(ioctl_upload), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_index(ioctl_index), .data_from_hps(data_from_hps),
		.data_to_hps(data_to_hps), .data_to_ram(data_to_ram), .ram_address(ram_address),
		.ram_read(ram_read), .ram_write(ram_write),
		.ram_intent_read(ram_intent_read), .ram_intent_write(ram_intent_write),
		.pause_cpu(pause_cpu), .configured(configured)
	);

	hiscore_checker #(.n_dump(dump_n), .n_writes(wr_n)) i_checker
	(
		.clk(clk), .arst_n(arst_n), .phase(phase), .done(done), .configured(configured),
		.ioctl_download(ioctl_download), .ioctl_upload(ioctl_upload), .ioctl_addr(ioctl_addr),
		.data_to_hps(data_to_hps), .data_to_ram(data_to_ram), .ram_address(ram_address),
		.ram_read(ram_read), .ram_write(ram_write),
		.ram_intent_read(ram_intent_read), .ram_intent_write(ram_intent_write),
		.pause_cpu(pause_cpu),
		.exp_dump(exp_dump), .exp_writes(exp_writes), .error_count(error_count)
	);

	// Background contents, every address bit counts
	function automatic byte_t fill_byte(input ram_addr_t a);
		return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h3C;
	endfunction

	// ------------------------------------------------------------
	// Host transfers
	// ------------------------------------------------------------
	task automatic download(input byte_t index, input int off, input int n);
		int k;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		for (k = 0; k < n; k++)
		begin
			@(posedge clk);
			#1;
			ioctl_addr    = ioctl_addr_t'(k);
			data_from_hps = pat[off + k][7:0];
			ioctl_wr      = 1'b1;
			@(posedge clk);
			#1;
			ioctl_wr = 1'b0;
		end
		@(posedge clk);
		#1;
		ioctl_download = 1'b0;  // Index stays put for the end detection
	endtask

	task automatic upload(input int n);
		int k;
		ioctl_index  = byte_t'(`HS_DUMP_INDEX);
		ioctl_upload = 1'b1;
		for (k = 0; k < n; k++)
		begin
			ioctl_addr = ioctl_addr_t'(k);  // One address per cycle
			@(posedge clk);
			#1;
		end
		ioctl_upload = 1'b0;
	endtask

	// One pause request from rise to release
	task automatic wait_pause_release();
		while (!pause_cpu)
		begin
			@(posedge clk);
			#1;
		end
		while (pause_cpu)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// ------------------------------------------------------------
	// Game side models
	// ------------------------------------------------------------
	always
	begin : pause_model
		@(posedge clk);
		#1;
		paused  = pause_d;    // Two cycles behind pause_cpu
		pause_d = pause_cpu;
	end

	always
	begin : game_ram_model
		int lat;
		@(posedge clk);
		#1;
		if (ram_read || ram_write)
		begin
			lat = 1 + int'($unsigned($random(seed)) % 4);
			repeat (lat) @(posedge clk);
			#1;
			if (ram_write)
				gram[ram_address] = data_to_ram;
			else
				data_from_ram = gram[ram_address];
			data_ready = 1'b1;  // Strobe drops on this edge
			@(posedge clk);
			#1;
			data_ready = 1'b0;
		end
	end

	initial
	begin : main_seq
		int a;
		clk            = 1'b0;
		arst_n         = 1'b0;
		game_reset     = 1'b1;  // Game held in reset while files load
		paused         = 1'b0;
		data_ready     = 1'b0;
		data_from_ram  = '0;
		ioctl_download = 1'b0;
		ioctl_upload   = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_index    = '0;
		data_from_hps  = '0;
		phase          = 0;
		done           = 1'b0;
		pause_d        = 1'b0;
		$readmemh("tests/hiscore_patterns.txt", pat);
		for (a = 0; a < 1024; a++)
			gram[a] = fill_byte(ram_addr_t'(a));
		for (a = 0; a < gram_n; a++)
			gram[gram_base + a] = pat[gram_off + a][7:0];
		for (a = 0; a < dump_n; a++)
			exp_dump[a] = pat[dump_off + a][7:0];
		for (a = 0; a < wr_n; a++)
			exp_writes[a] = {pat[wr_off + 2 * a][9:0], pat[wr_off + 2 * a + 1][7:0]};
		// Header waits times four plus a budget per transferred byte
		limit_cycles = 4 * ({pat[0][7:0], pat[1][7:0], pat[2][7:0], pat[3][7:0]}
			+ {pat[4][7:0], pat[5][7:0]} + pat[14][7:0]) + 200 * (cfg_n + 2 * dump_n);
		armed = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		phase  = 1;
		download(byte_t'(`HS_CONFIG_INDEX), 0, cfg_n);
		repeat (3) @(posedge clk);
		#1;
		phase = 2;
		download(byte_t'(`HS_DUMP_INDEX), dump_off, dump_n);
		upload(dump_n);
		repeat (4) @(posedge clk);
		#1;
		phase = 3;
		gram[gram_base] = ~gram[gram_base];  // Break the start byte of entry 0
		game_reset      = 1'b0;
		wait_pause_release();
		gram[gram_base] = pat[gram_off][7:0];  // Fix it before the retry
		phase           = 4;
		wait_pause_release();
		phase = 5;
		repeat (40) @(posedge clk);
		#1;
		game_reset = 1'b1;
		@(posedge clk);
		#1;
		phase = 6;
		done  = 1'b1;
		@(posedge clk);
		#1;
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin : watchdog
		wait (armed);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not complete", limit_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/hiscore_pkg.sv
hdl/hiscore_dpram.sv
hdl/hiscore_cfg_decode.sv
hdl/hiscore_restore_exec.sv
hdl/hiscore_dump_store.sv
hdl/hiscore_top.sv
tests/hiscore_checker.sv
tests/tb_hiscore.sv
